/* design/DecodePkg.sv */
// ==========================================================
// Shared definitions for the two-wide decode stage
// Widths, opcode enum, instruction and micro-op structs,
// bundle lanes and output lanes
// ==========================================================
`default_nettype none

package DecodePkg;

    localparam int DECODE_WIDTH = 2;
    localparam int MICRO_OP_MAX_NUM = 2;
    localparam int ALL_MICRO_OP_NUM = DECODE_WIDTH * MICRO_OP_MAX_NUM;
    localparam int PC_WIDTH = 16;

    // Toy 16-bit ISA opcodes
    typedef enum logic [3:0] {
        NOP      = 4'd0,
        ADD      = 4'd1,
        SUB      = 4'd2,
        LOAD     = 4'd3,
        STORE    = 4'd4,
        LOADPAIR = 4'd5,
        BRANCH   = 4'd6,
        JUMP     = 4'd7,
        CSR      = 4'd8
    } OpCode;

    typedef struct packed {
        OpCode             opcode;
        logic [3:0]        rd;
        logic [3:0]        rs;
        logic signed [3:0] imm;
    } Insn;

    typedef struct packed {
        logic                taken;
        logic [PC_WIDTH-1:0] target;
    } BranchPred;

    // One lane of a fetch bundle
    typedef struct packed {
        logic                valid;
        Insn                 insn;
        logic [PC_WIDTH-1:0] pc;
        BranchPred           pred;
    } FetchLane;

    typedef struct packed {
        logic              valid;
        logic              serialized;
        logic              mid;
        OpCode             opcode;
        logic [3:0]        rd;
        logic [3:0]        rs;
        logic signed [3:0] imm;
    } MicroOp;

    // Registered form of a lane, instruction plus its expansion
    typedef struct packed {
        FetchLane                           fetch;
        MicroOp [MICRO_OP_MAX_NUM-1:0]      mops;
    } DecodeLane;

    typedef struct packed {
        logic                valid;
        MicroOp              mop;
        logic [PC_WIDTH-1:0] pc;
        BranchPred           pred;
    } PickedOp;

    typedef logic [$clog2(ALL_MICRO_OP_NUM)-1:0] MopIndex;

endpackage

`default_nettype wire

/* design/MicroOpExpander.sv */
// ==========================================================
// Combinational pre-decode of bundle lanes into micro ops
// ==========================================================
`default_nettype none

module MicroOpExpander (
    input  wire DecodePkg::FetchLane  fetchLane [DecodePkg::DECODE_WIDTH],
    output DecodePkg::DecodeLane      decodeLane [DecodePkg::DECODE_WIDTH]
);

    // Plain one-to-one translation of each lane
    DecodePkg::MicroOp baseOp [DecodePkg::DECODE_WIDTH];

    always_comb begin
        for (int i = 0; i < DecodePkg::DECODE_WIDTH; i++) begin
            baseOp[i] = '0;
            baseOp[i].valid = fetchLane[i].valid;
            baseOp[i].opcode = fetchLane[i].insn.opcode;
            baseOp[i].rd = fetchLane[i].insn.rd;
            baseOp[i].rs = fetchLane[i].insn.rs;
            baseOp[i].imm = fetchLane[i].insn.imm;

            decodeLane[i].fetch = fetchLane[i];
            decodeLane[i].mops[0] = baseOp[i];
            decodeLane[i].mops[1] = '0;

            case (fetchLane[i].insn.opcode)
                DecodePkg::NOP: begin
                    decodeLane[i].mops[0].valid = 1'b0;
                end
                DecodePkg::LOADPAIR: begin
                    // Split into two loads, second one on the next register pair half
                    decodeLane[i].mops[0].opcode = DecodePkg::LOAD;
                    decodeLane[i].mops[1] = baseOp[i];
                    decodeLane[i].mops[1].opcode = DecodePkg::LOAD;
                    decodeLane[i].mops[1].mid = 1'b1;
                    decodeLane[i].mops[1].rd = fetchLane[i].insn.rd + 4'd1;
                    decodeLane[i].mops[1].imm = fetchLane[i].insn.imm + 4'sd2;
                end
                DecodePkg::CSR: begin
                    // CSR access must leave decode on its own
                    decodeLane[i].mops[0].serialized = 1'b1;
                end
                default: begin
                    // Other opcodes keep the single translated op
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/MicroOpPicker.sv */
// ==========================================================
// Micro-op picker, up to two slots per cycle in slot order
// with serialized ops sent alone
// ==========================================================
`default_nettype none

module MicroOpPicker (
    input  wire [DecodePkg::ALL_MICRO_OP_NUM-1:0] pending,
    input  wire [DecodePkg::ALL_MICRO_OP_NUM-1:0] serialize,
    output logic [DecodePkg::DECODE_WIDTH-1:0]    picked,
    output DecodePkg::MopIndex                    pickedIndex [DecodePkg::DECODE_WIDTH],
    output logic [DecodePkg::ALL_MICRO_OP_NUM-1:0] remaining
);

    logic stop;
    logic found;

    always_comb begin
        remaining = pending;
        stop = 1'b0;
        found = 1'b0;

        for (int i = 0; i < DecodePkg::DECODE_WIDTH; i++) begin
            picked[i] = 1'b0;
            pickedIndex[i] = '0;
            found = 1'b0;

            for (int s = 0; s < DecodePkg::ALL_MICRO_OP_NUM; s++) begin
                if (!stop && !found && remaining[s]) begin
                    found = 1'b1;
                    if (serialize[s] && i != 0) begin
                        // Serialized op behind a normal one waits a cycle
                        stop = 1'b1;
                    end else begin
                        picked[i] = 1'b1;
                        pickedIndex[i] = DecodePkg::MopIndex'(s);
                        remaining[s] = 1'b0;
                        // Nothing may follow a serialized op
                        if (serialize[s]) begin
                            stop = 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/DecodedBranchResolver.sv */
// ==========================================================
// Early branch resolver for the decode stage
// Checks direct jumps and non-branches against the prediction,
// masks younger lanes and computes the recovery PC
// ==========================================================
`default_nettype none

module DecodedBranchResolver (
    input  wire                                clk,
    input  wire                                rstN,
    input  wire                                hold,
    input  wire                                decodeComplete,
    input  wire DecodePkg::FetchLane           laneIn [DecodePkg::DECODE_WIDTH],
    output logic [DecodePkg::DECODE_WIDTH-1:0] laneValidOut,
    output logic                               flushTriggered,
    output logic [DecodePkg::PC_WIDTH-1:0]     recoveredPc
);

    logic [DecodePkg::DECODE_WIDTH-1:0] combValid;
    logic [DecodePkg::DECODE_WIDTH-1:0] savedValid;
    logic                               combTrig;
    logic                               savedTrig;
    logic [DecodePkg::PC_WIDTH-1:0]     combPc;
    logic [DecodePkg::PC_WIDTH-1:0]     savedPc;
    logic [DecodePkg::PC_WIDTH-1:0]     jumpTarget [DecodePkg::DECODE_WIDTH];

    // Set after the first cycle of a multi-cycle bundle
    logic resolved;

    always_comb begin
        combTrig = 1'b0;
        combPc = '0;
        for (int i = 0; i < DecodePkg::DECODE_WIDTH; i++) begin
            // pc + 2*imm, immediate sign-extended
            jumpTarget[i] = laneIn[i].pc
                + {{(DecodePkg::PC_WIDTH - 5){laneIn[i].insn.imm[3]}},
                   laneIn[i].insn.imm, 1'b0};

            // Lanes behind the first trigger are dropped
            combValid[i] = laneIn[i].valid && !combTrig;

            if (combValid[i]) begin
                if (laneIn[i].insn.opcode == DecodePkg::JUMP) begin
                    if (!(laneIn[i].pred.taken && laneIn[i].pred.target == jumpTarget[i])) begin
                        combTrig = 1'b1;
                        combPc = jumpTarget[i];
                    end
                end else if (laneIn[i].insn.opcode != DecodePkg::BRANCH
                             && laneIn[i].pred.taken) begin
                    combTrig = 1'b1;
                    combPc = laneIn[i].pc + DecodePkg::PC_WIDTH'(2);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resolved <= 1'b0;
        end else if (!hold) begin
            resolved <= !decodeComplete;
        end
    end

    // Snapshot of the first cycle's result
    always_ff @(posedge clk) begin
        if (!hold && !resolved) begin
            savedValid <= combValid;
            savedTrig <= combTrig;
            savedPc <= combPc;
        end
    end

    always_comb begin
        laneValidOut = resolved ? savedValid : combValid;
        flushTriggered = decodeComplete && (resolved ? savedTrig : combTrig);
        recoveredPc = resolved ? savedPc : combPc;
    end

endmodule

`default_nettype wire

/* design/DecodeStage.sv */
// ==========================================================
// Decode stage
// Bundle register, pending micro-op tracking, own stall,
// early flush and the two output lanes
// ==========================================================
`default_nettype none

module DecodeStage (
    input  wire                            clk,
    input  wire                            rstN,
    input  wire DecodePkg::DecodeLane      decodeLane [DecodePkg::DECODE_WIDTH],
    input  wire                            fetchValid,
    input  wire                            stall,
    input  wire                            clear,
    output logic                           ready,
    output DecodePkg::PickedOp             pickedOp [DecodePkg::DECODE_WIDTH],
    output logic                           nextFlush,
    output logic [DecodePkg::PC_WIDTH-1:0] recoveredPc
);

    DecodePkg::DecodeLane pipeReg [DecodePkg::DECODE_WIDTH];
    DecodePkg::FetchLane  laneIn [DecodePkg::DECODE_WIDTH];
    DecodePkg::MicroOp    allMops [DecodePkg::ALL_MICRO_OP_NUM];

    logic [DecodePkg::ALL_MICRO_OP_NUM-1:0] pendingReg;
    logic [DecodePkg::ALL_MICRO_OP_NUM-1:0] curPending;
    logic [DecodePkg::ALL_MICRO_OP_NUM-1:0] livePending;
    logic [DecodePkg::ALL_MICRO_OP_NUM-1:0] serialize;
    logic [DecodePkg::ALL_MICRO_OP_NUM-1:0] remaining;

    logic [DecodePkg::DECODE_WIDTH-1:0] picked;
    logic [DecodePkg::DECODE_WIDTH-1:0] laneValid;
    DecodePkg::MopIndex                 pickedIndex [DecodePkg::DECODE_WIDTH];

    logic initiate;
    logic complete;
    logic stallUpper;
    logic resolverHold;
    logic flushTriggered;

    // Bundle register
    always_ff @(posedge clk) begin
        if (!rstN || clear) begin
            for (int i = 0; i < DecodePkg::DECODE_WIDTH; i++) begin
                pipeReg[i].fetch.valid <= 1'b0;
            end
        end else if (ready) begin
            for (int i = 0; i < DecodePkg::DECODE_WIDTH; i++) begin
                pipeReg[i] <= decodeLane[i];
                if (!fetchValid) begin
                    pipeReg[i].fetch.valid <= 1'b0;
                end
            end
        end
    end

    // Pending slots advance only when downstream accepts
    always_ff @(posedge clk) begin
        if (!rstN || clear) begin
            pendingReg <= '0;
            initiate <= 1'b1;
        end else if (!stall) begin
            initiate <= complete;
            pendingReg <= remaining;
        end
    end

    always_comb begin
        for (int i = 0; i < DecodePkg::DECODE_WIDTH; i++) begin
            laneIn[i] = pipeReg[i].fetch;
            for (int j = 0; j < DecodePkg::MICRO_OP_MAX_NUM; j++) begin
                allMops[i * DecodePkg::MICRO_OP_MAX_NUM + j] = pipeReg[i].mops[j];
                serialize[i * DecodePkg::MICRO_OP_MAX_NUM + j] = pipeReg[i].mops[j].serialized;
                // Fresh bundle takes its valid bits straight from the register
                curPending[i * DecodePkg::MICRO_OP_MAX_NUM + j] = initiate
                    ? (pipeReg[i].mops[j].valid && pipeReg[i].fetch.valid)
                    : pendingReg[i * DecodePkg::MICRO_OP_MAX_NUM + j];
                // Flushed lanes drop out before the pick
                livePending[i * DecodePkg::MICRO_OP_MAX_NUM + j] =
                    curPending[i * DecodePkg::MICRO_OP_MAX_NUM + j] && laneValid[i];
            end
        end
    end

    MicroOpPicker picker_i (
        .pending    (livePending),
        .serialize  (serialize),
        .picked     (picked),
        .pickedIndex(pickedIndex),
        .remaining  (remaining)
    );

    DecodedBranchResolver resolver_i (
        .clk           (clk),
        .rstN          (rstN),
        .hold          (resolverHold),
        .decodeComplete(complete),
        .laneIn        (laneIn),
        .laneValidOut  (laneValid),
        .flushTriggered(flushTriggered),
        .recoveredPc   (recoveredPc)
    );

    always_comb begin
        // A clear ends the bundle at once
        complete = clear || (remaining == '0);
        stallUpper = !complete;
        ready = !stall && !stallUpper;
        resolverHold = stall && !clear;
        nextFlush = flushTriggered && !clear;
    end

    // Map each picked slot back to its instruction lane
    always_comb begin
        int src;
        src = 0;
        for (int k = 0; k < DecodePkg::DECODE_WIDTH; k++) begin
            src = int'(pickedIndex[k]) / DecodePkg::MICRO_OP_MAX_NUM;
            pickedOp[k].valid = picked[k] && !clear;
            pickedOp[k].mop = allMops[pickedIndex[k]];
            pickedOp[k].pc = pipeReg[src].fetch.pc;
            pickedOp[k].pred = pipeReg[src].fetch.pred;
        end
    end

endmodule

`default_nettype wire

/* design/DecodeTop.sv */
// ==========================================================
// Decode front end top level
// Pre-decode expander feeding the decode stage
// ==========================================================
`default_nettype none

module DecodeTop (
    input  wire                            clk,
    input  wire                            rstN,
    input  wire DecodePkg::FetchLane       fetchLane [DecodePkg::DECODE_WIDTH],
    input  wire                            fetchValid,
    input  wire                            stall,
    input  wire                            clear,
    output logic                           ready,
    output DecodePkg::PickedOp             pickedOp [DecodePkg::DECODE_WIDTH],
    output logic                           nextFlush,
    output logic [DecodePkg::PC_WIDTH-1:0] recoveredPc
);

    DecodePkg::DecodeLane decodeLane [DecodePkg::DECODE_WIDTH];

    MicroOpExpander expander_i (
        .fetchLane (fetchLane),
        .decodeLane(decodeLane)
    );

    DecodeStage stage_i (
        .clk        (clk),
        .rstN       (rstN),
        .decodeLane (decodeLane),
        .fetchValid (fetchValid),
        .stall      (stall),
        .clear      (clear),
        .ready      (ready),
        .pickedOp   (pickedOp),
        .nextFlush  (nextFlush),
        .recoveredPc(recoveredPc)
    );

endmodule

`default_nettype wire

/* bench/DecodeTb_assert.sv */
// ==========================================================
// Concurrent checks bound to the decode stage
// Lane fill order, serialized ops alone, flush masked by clear
// ==========================================================
`default_nettype none

module DecodeTbAssert (
    input wire                     clk,
    input wire                     rstN,
    input wire                     clear,
    input wire                     nextFlush,
    input wire DecodePkg::PickedOp pickedOp [DecodePkg::DECODE_WIDTH]
);

    // Output lanes fill from lane 0 upward
    laneOrder: assert property (@(posedge clk) disable iff (!rstN)
        !pickedOp[0].valid |-> !pickedOp[1].valid)
        else $error("pickedOp lane 1 valid while lane 0 is empty");

    // Serialized op leaves decode alone
    serializedAlone: assert property (@(posedge clk) disable iff (!rstN)
        (pickedOp[0].valid && pickedOp[0].mop.serialized) |-> !pickedOp[1].valid)
        else $error("serialized micro op on lane 0 shares the cycle with lane 1");

    clearMasksFlush: assert property (@(posedge clk) disable iff (!rstN)
        clear |-> !nextFlush)
        else $error("nextFlush high while clear is high");

endmodule

`default_nettype wire

/* bench/DecodeTb.sv */
// ==========================================================
// Testbench for the decode front end
// Clock and reset, stimulus table, lane collection and checks
// ==========================================================
`default_nettype none

module DecodeTb;

    logic                           clk;
    logic                           rstN;
    logic                           fetchValid;
    logic                           stall;
    logic                           clear;
    logic                           ready;
    logic                           nextFlush;
    logic [DecodePkg::PC_WIDTH-1:0] recoveredPc;
    DecodePkg::FetchLane            fetchLane [DecodePkg::DECODE_WIDTH];
    DecodePkg::PickedOp             pickedOp [DecodePkg::DECODE_WIDTH];

    // Expected micro op, hex nibbles opcode, rd, imm then a 16-bit pc
    typedef struct packed {
        logic [3:0]                     opcode;
        logic [3:0]                     rd;
        logic [3:0]                     imm;
        logic [DecodePkg::PC_WIDTH-1:0] pc;
    } ExpOp;

    typedef struct packed {
        DecodePkg::FetchLane [DecodePkg::DECODE_WIDTH-1:0] lanes;
        logic [7:0]                                        stallMask;
        logic [3:0]                                        clearCycle;
        logic [3:0]                                        busyCycles;
        logic                                              expFlush;
        logic [DecodePkg::PC_WIDTH-1:0]                    expPc;
        logic [2:0]                                        opCount;
        ExpOp [0:DecodePkg::ALL_MICRO_OP_NUM-1]            ops;
    } TestRow;

    TestRow rows [$];
    int     mismatchCount = 0;
    int     otherCount = 0;
    int     cycleCount = 0;

    DecodeTop dut_i (
        .clk        (clk),
        .rstN       (rstN),
        .fetchLane  (fetchLane),
        .fetchValid (fetchValid),
        .stall      (stall),
        .clear      (clear),
        .ready      (ready),
        .pickedOp   (pickedOp),
        .nextFlush  (nextFlush),
        .recoveredPc(recoveredPc)
    );

    bind DecodeStage DecodeTbAssert assert_i (
        .clk(clk), .rstN(rstN), .clear(clear), .nextFlush(nextFlush), .pickedOp(pickedOp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Valid lane from a raw instruction word {opcode, rd, rs, imm}
    function automatic DecodePkg::FetchLane makeLane(input logic [15:0] insn,
            input logic [15:0] pc, input logic taken = 1'b0, input logic [15:0] target = '0);
        return {1'b1, insn, pc, taken, target};
    endfunction

    task automatic addRow(input DecodePkg::FetchLane lane0, input DecodePkg::FetchLane lane1,
            input logic [7:0] stallMask, input logic [3:0] clearCycle, input logic [3:0] busy,
            input logic flush, input logic [15:0] flushPc, input logic [2:0] count,
            input ExpOp [0:3] ops);
        rows.push_back(TestRow'({lane1, lane0, stallMask, clearCycle, busy, flush, flushPc,
                                 count, ops}));
    endtask

    task automatic loadRows();
        // Lanes, stall mask, clear cycle (F is none), busy cycles, flush, flush pc, count, ops
        addRow(makeLane(16'h1121, 16'h0100), makeLane(16'h234E, 16'h0102), 8'h00, 4'hF,
            4'd1, 1'b0, 16'h0000, 3'd2, {28'h1_1_1_0100, 28'h2_3_E_0102, 56'h0});
        addRow(makeLane(16'h5411, 16'h0110), makeLane(16'h1620, 16'h0112), 8'h00, 4'hF,
            4'd2, 1'b0, 16'h0000, 3'd3, {28'h3_4_1_0110, 28'h3_5_3_0110, 28'h1_6_0_0112, 28'h0});
        addRow(makeLane(16'h1112, 16'h0120), makeLane(16'h8200, 16'h0122), 8'h00, 4'hF,
            4'd2, 1'b0, 16'h0000, 3'd2, {28'h1_1_2_0120, 28'h8_2_0_0122, 56'h0});
        addRow(makeLane(16'h8700, 16'h0130), makeLane(16'h2811, 16'h0132), 8'h00, 4'hF,
            4'd2, 1'b0, 16'h0000, 3'd2, {28'h8_7_0_0130, 28'h2_8_1_0132, 56'h0});
        // Jump predicted not taken, then one predicted right
        addRow(makeLane(16'h7003, 16'h0140), makeLane(16'h1520, 16'h0142), 8'h00, 4'hF,
            4'd1, 1'b1, 16'h0146, 3'd1, {28'h7_0_3_0140, 84'h0});
        addRow(makeLane(16'h700E, 16'h0150, 1'b1, 16'h014C),
            makeLane(16'h6004, 16'h0152, 1'b1, 16'h015A), 8'h00, 4'hF,
            4'd1, 1'b0, 16'h0000, 3'd2, {28'h7_0_E_0150, 28'h6_0_4_0152, 56'h0});
        // Stall after the first pick of a load pair
        addRow(makeLane(16'h5230, 16'h0160), makeLane(16'h2911, 16'h0162), 8'h06, 4'hF,
            4'd2, 1'b0, 16'h0000, 3'd3, {28'h3_2_0_0160, 28'h3_3_2_0160, 28'h2_9_1_0162, 28'h0});
        // Cleared mid-bundle, the pending add and its flush are lost
        addRow(makeLane(16'h5A01, 16'h0170), makeLane(16'h1100, 16'h0172, 1'b1, 16'h0300),
            8'h00, 4'h1, 4'd2, 1'b0, 16'h0000, 3'd2, {28'h3_A_1_0170, 28'h3_B_3_0170, 56'h0});
        addRow(makeLane(16'h2100, 16'h0180, 1'b1, 16'h0200), makeLane(16'h1200, 16'h0182),
            8'h00, 4'hF, 4'd1, 1'b1, 16'h0182, 3'd1, {28'h2_1_0_0180, 84'h0});
        addRow(makeLane(16'h0000, 16'h0190), makeLane(16'h131F, 16'h0192), 8'h00, 4'hF,
            4'd1, 1'b0, 16'h0000, 3'd1, {28'h1_3_F_0192, 84'h0});
    endtask

    task automatic expectEqual(input string name, input logic [15:0] expected,
            input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic checkLane(input int k, input ExpOp want);
        expectEqual($sformatf("pickedOp[%0d].mop.opcode", k), want.opcode,
            pickedOp[k].mop.opcode);
        expectEqual($sformatf("pickedOp[%0d].mop.rd", k), want.rd, pickedOp[k].mop.rd);
        expectEqual($sformatf("pickedOp[%0d].mop.imm", k), want.imm,
            unsigned'(pickedOp[k].mop.imm));
        expectEqual($sformatf("pickedOp[%0d].pc", k), want.pc, pickedOp[k].pc);
    endtask

    initial begin
        TestRow                         row;
        int                             got;
        int                             busy;
        logic                           done;
        logic                           flushSeen;
        logic [DecodePkg::PC_WIDTH-1:0] flushPc;

        rstN <= 1'b0;
        fetchValid <= 1'b0;
        stall <= 1'b0;
        clear <= 1'b0;
        fetchLane[0] <= '0;
        fetchLane[1] <= '0;
        loadRows();
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        expectEqual("pickedOp[0].valid", 1'b0, pickedOp[0].valid);
        expectEqual("pickedOp[1].valid", 1'b0, pickedOp[1].valid);
        expectEqual("nextFlush", 1'b0, nextFlush);
        expectEqual("ready", 1'b1, ready);

        foreach (rows[r]) begin
            row = rows[r];
            got = 0;
            busy = 0;
            done = 1'b0;
            flushSeen = 1'b0;
            flushPc = '0;
            @(posedge clk);
            fetchLane[0] <= row.lanes[0];
            fetchLane[1] <= row.lanes[1];
            fetchValid <= 1'b1;
            stall <= 1'b0;
            clear <= 1'b0;
            @(negedge clk);
            if (!ready) begin
                $display("Row %0d was offered while the stage was not ready", r);
                otherCount++;
            end
            // Bundle is captured at this edge
            @(posedge clk);
            fetchValid <= 1'b0;
            for (int c = 0; c < 8 && !done; c++) begin
                stall <= row.stallMask[c];
                clear <= (c == row.clearCycle);
                @(negedge clk);
                // Lanes are taken only in unstalled cycles
                if (!stall) begin
                    busy++;
                    for (int k = 0; k < DecodePkg::DECODE_WIDTH; k++) begin
                        if (pickedOp[k].valid) begin
                            if (got >= row.opCount) begin
                                $display("Row %0d gave an extra micro op on lane %0d", r, k);
                                otherCount++;
                            end else begin
                                checkLane(k, row.ops[got]);
                            end
                            got++;
                        end
                    end
                    if (nextFlush) begin
                        flushSeen = 1'b1;
                        flushPc = recoveredPc;
                    end
                    done = ready;
                end
                if (!done) begin
                    @(posedge clk);
                end
            end
            if (got < row.opCount) begin
                $display("Row %0d is missing micro ops, %0d of %0d seen", r, got, row.opCount);
                otherCount++;
            end
            if (busy != row.busyCycles) begin
                $display("Row %0d held the stage for %0d cycles instead of %0d", r, busy,
                    row.busyCycles);
                otherCount++;
            end
            expectEqual("nextFlush", row.expFlush, flushSeen);
            if (row.expFlush) begin
                expectEqual("recoveredPc", row.expPc, flushPc);
            end
        end

        @(posedge clk);
        $display("Error counts: %0d mismatches, %0d other errors", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run limit of eight cycles per row plus twenty
    initial begin
        while (cycleCount < 8 * rows.size() + 20) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the test sequence did not complete", cycleCount);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
design/DecodePkg.sv
design/MicroOpExpander.sv
design/MicroOpPicker.sv
design/DecodedBranchResolver.sv
design/DecodeStage.sv
design/DecodeTop.sv
bench/DecodeTb_assert.sv
bench/DecodeTb.sv

/* run.sh */
#!/bin/sh
# Build and run the decode testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module DecodeTb \
    -Mdir obj_dir -o DecodeSim
./obj_dir/DecodeSim | tee sim.log
if grep -q "^Finished with no errors$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
